/* jtag_pkg.sv */
package jtag_pkg;

	// IEEE 1149.1 controller states
	typedef enum logic [3:0] {
		TAP_RESET      = 4'h0,
		TAP_IDLE       = 4'h1,
		TAP_SELECT_DR  = 4'h2,
		TAP_CAPTURE_DR = 4'h3,
		TAP_SHIFT_DR   = 4'h4,
		TAP_EXIT1_DR   = 4'h5,
		TAP_PAUSE_DR   = 4'h6,
		TAP_EXIT2_DR   = 4'h7,
		TAP_UPDATE_DR  = 4'h8,
		TAP_SELECT_IR  = 4'h9,
		TAP_CAPTURE_IR = 4'ha,
		TAP_SHIFT_IR   = 4'hb,
		TAP_EXIT1_IR   = 4'hc,
		TAP_PAUSE_IR   = 4'hd,
		TAP_EXIT2_IR   = 4'he,
		TAP_UPDATE_IR  = 4'hf
	} tap_state_t;

	localparam int IR_WIDTH = 4;

	// Unlisted codes are treated as bypass
	localparam logic [IR_WIDTH-1:0] INSTR_IDCODE   = 4'b0001;
	localparam logic [IR_WIDTH-1:0] INSTR_REG_ADDR = 4'b0010;
	localparam logic [IR_WIDTH-1:0] INSTR_REG_DATA = 4'b0011;
	localparam logic [IR_WIDTH-1:0] INSTR_BYPASS   = 4'b1111;

	// Version, part number, manufacturer, mandatory 1 in bit 0
	localparam logic [31:0] IDCODE_VALUE = 32'h1a57_2e4f;

endpackage

/* dbg_reg_pkg.sv */
package dbg_reg_pkg;

	localparam int REG_ADDR_WIDTH = 8;
	localparam int REG_DATA_WIDTH = 16;

	// Configuration registers, read and write
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL      = 8'h00;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_PRBS_MODE = 8'h01;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_PRBS_INIT = 8'h02;

	// Status registers, read only
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_STAT_EXT   = 8'h40;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CORRECT_LO = 8'h41;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CORRECT_HI = 8'h42;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TOTAL_LO   = 8'h43;
	localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TOTAL_HI   = 8'h44;

	// Power-up values
	localparam logic [REG_DATA_WIDTH-1:0] CTRL_RESET      = 16'h8001;
	localparam logic [REG_DATA_WIDTH-1:0] PRBS_INIT_RESET = 16'h007f;

endpackage

/* jtag_pin_sync.sv */
`default_nettype none

module jtag_pin_sync (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_n_o
);
	logic [1:0] tck_ff;
	logic [1:0] tms_ff;
	logic [1:0] tdi_ff;
	logic [1:0] trst_n_ff;
	logic tck_d;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			tck_ff <= '0;
			tms_ff <= '0;
			tdi_ff <= '0;
			trst_n_ff <= '1;
			tck_d <= 1'b0;
		end else begin
			tck_ff <= {tck_ff[0], tck_i};
			tms_ff <= {tms_ff[0], tms_i};
			tdi_ff <= {tdi_ff[0], tdi_i};
			trst_n_ff <= {trst_n_ff[0], trst_n_i};
			tck_d <= tck_ff[1];
		end
	end

	// Edge strobes from the last two synchronized TCK samples
	assign tck_rise_o = tck_ff[1] & ~tck_d;
	assign tck_fall_o = ~tck_ff[1] & tck_d;

	assign tms_o = tms_ff[1];
	assign tdi_o = tdi_ff[1];
	assign trst_n_o = trst_n_ff[1];

	// TCK phases of at least 4 clk cycles keep the strobes apart
	assert property (@(posedge clk) disable iff (rst_i)
		(tck_rise_o || tck_fall_o) |->
			!$past(tck_rise_o || tck_fall_o, 1) &&
			!$past(tck_rise_o || tck_fall_o, 2) &&
			!$past(tck_rise_o || tck_fall_o, 3));

endmodule

`default_nettype wire

/* jtag_tap.sv */
`default_nettype none

module jtag_tap import jtag_pkg::*, dbg_reg_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_rise_i,
	input wire logic tck_fall_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	input wire logic [REG_DATA_WIDTH-1:0] rd_data_i,
	output logic tdo_o,
	output logic [REG_ADDR_WIDTH-1:0] reg_addr_o,
	output logic [REG_DATA_WIDTH-1:0] wr_data_o,
	output logic wr_en_o
);
	tap_state_t state;
	tap_state_t state_nxt;
	logic [IR_WIDTH-1:0] ir_shift;
	logic [IR_WIDTH-1:0] ir;
	logic [$bits(IDCODE_VALUE)-1:0] dr;
	logic tap_rst;
	logic upd_dr;

	assign tap_rst = rst_i || !trst_n_i;
	assign upd_dr = tck_rise_i && !tap_rst && state_nxt == TAP_UPDATE_DR;

	always_comb begin
		case (state)
			TAP_RESET:      state_nxt = tms_i ? TAP_RESET : TAP_IDLE;
			TAP_IDLE:       state_nxt = tms_i ? TAP_SELECT_DR : TAP_IDLE;
			TAP_SELECT_DR:  state_nxt = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR: state_nxt = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:   state_nxt = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:   state_nxt = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:   state_nxt = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:   state_nxt = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:  state_nxt = tms_i ? TAP_SELECT_DR : TAP_IDLE;
			TAP_SELECT_IR:  state_nxt = tms_i ? TAP_RESET : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR: state_nxt = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:   state_nxt = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:   state_nxt = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:   state_nxt = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:   state_nxt = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			TAP_UPDATE_IR:  state_nxt = tms_i ? TAP_SELECT_DR : TAP_IDLE;
			default:        state_nxt = TAP_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (tap_rst) begin
			state <= TAP_RESET;
			ir <= INSTR_IDCODE;
			wr_en_o <= 1'b0;
		end else begin
			wr_en_o <= upd_dr && ir == INSTR_REG_DATA;
			if (tck_rise_i) begin
				state <= state_nxt;
				if (state_nxt == TAP_RESET)
					ir <= INSTR_IDCODE;
				else if (state_nxt == TAP_UPDATE_IR)
					ir <= ir_shift;
			end
		end
	end

	// Capture and shift; chain length follows the instruction
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			case (state)
				TAP_CAPTURE_DR: begin
					case (ir)
						INSTR_IDCODE:   dr <= IDCODE_VALUE;
						INSTR_REG_ADDR: dr[REG_ADDR_WIDTH-1:0] <= reg_addr_o;
						INSTR_REG_DATA: dr[REG_DATA_WIDTH-1:0] <= rd_data_i;
						default:        dr[0] <= 1'b0;
					endcase
				end
				TAP_SHIFT_DR: begin
					case (ir)
						INSTR_IDCODE:   dr <= {tdi_i, dr[$bits(dr)-1:1]};
						INSTR_REG_ADDR: dr[REG_ADDR_WIDTH-1:0] <= {tdi_i, dr[REG_ADDR_WIDTH-1:1]};
						INSTR_REG_DATA: dr[REG_DATA_WIDTH-1:0] <= {tdi_i, dr[REG_DATA_WIDTH-1:1]};
						default:        dr[0] <= tdi_i;
					endcase
				end
				TAP_CAPTURE_IR: ir_shift <= IR_WIDTH'(1);
				TAP_SHIFT_IR:   ir_shift <= {tdi_i, ir_shift[IR_WIDTH-1:1]};
				default: ;
			endcase
		end
		if (upd_dr && ir == INSTR_REG_DATA)
			wr_data_o <= dr[REG_DATA_WIDTH-1:0];
	end

	// Address survives a TAP reset so the register file keeps its selection
	always_ff @(posedge clk) begin
		if (rst_i)
			reg_addr_o <= '0;
		else if (upd_dr && ir == INSTR_REG_ADDR)
			reg_addr_o <= dr[REG_ADDR_WIDTH-1:0];
	end

	// TDO changes on the falling edge only
	always_ff @(posedge clk) begin
		if (tap_rst) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			case (state)
				TAP_SHIFT_DR: tdo_o <= dr[0];
				TAP_SHIFT_IR: tdo_o <= ir_shift[0];
				default:      tdo_o <= 1'b0;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst_i)
		wr_en_o |-> state == TAP_UPDATE_DR && ir == INSTR_REG_DATA);

	assert property (@(posedge clk) disable iff (rst_i)
		state == TAP_RESET |-> ir == INSTR_IDCODE);

endmodule

`default_nettype wire

/* dbg_reg_file.sv */
`default_nettype none

module dbg_reg_file import dbg_reg_pkg::*; #(
	parameter int COUNT_WIDTH = 32
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic wr_en_i,
	input wire logic [REG_ADDR_WIDTH-1:0] reg_addr_i,
	input wire logic [REG_DATA_WIDTH-1:0] wr_data_i,
	input wire logic [REG_DATA_WIDTH-1:0] stat_i,
	input wire logic [COUNT_WIDTH-1:0] correct_cnt_i,
	input wire logic [COUNT_WIDTH-1:0] total_cnt_i,
	output logic [REG_DATA_WIDTH-1:0] rd_data_o,
	output logic [REG_DATA_WIDTH-1:0] ctrl_o,
	output logic prbs_en_o,
	output logic [6:0] prbs_seed_o
);
	localparam int HALF = COUNT_WIDTH / 2;

	logic [REG_DATA_WIDTH-1:0] ctrl_q;
	logic [REG_DATA_WIDTH-1:0] mode_q;
	logic [REG_DATA_WIDTH-1:0] init_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ctrl_q <= CTRL_RESET;
			mode_q <= '0;
			init_q <= PRBS_INIT_RESET;
		end else if (wr_en_i) begin
			// Status addresses fall through and are not written
			case (reg_addr_i)
				ADDR_CTRL:      ctrl_q <= wr_data_i;
				ADDR_PRBS_MODE: mode_q <= wr_data_i;
				ADDR_PRBS_INIT: init_q <= wr_data_i;
				default: ;
			endcase
		end
	end

	assign ctrl_o = ctrl_q;
	assign prbs_en_o = mode_q[0];
	assign prbs_seed_o = init_q[6:0];

	// Counters read back as two halves
	always_comb begin
		case (reg_addr_i)
			ADDR_CTRL:       rd_data_o = ctrl_q;
			ADDR_PRBS_MODE:  rd_data_o = mode_q;
			ADDR_PRBS_INIT:  rd_data_o = init_q;
			ADDR_STAT_EXT:   rd_data_o = stat_i;
			ADDR_CORRECT_LO: rd_data_o = REG_DATA_WIDTH'(correct_cnt_i[HALF-1:0]);
			ADDR_CORRECT_HI: rd_data_o = REG_DATA_WIDTH'(correct_cnt_i[COUNT_WIDTH-1:HALF]);
			ADDR_TOTAL_LO:   rd_data_o = REG_DATA_WIDTH'(total_cnt_i[HALF-1:0]);
			ADDR_TOTAL_HI:   rd_data_o = REG_DATA_WIDTH'(total_cnt_i[COUNT_WIDTH-1:HALF]);
			default:         rd_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* prbs_checker.sv */
`default_nettype none

module prbs_checker #(
	parameter int COUNT_WIDTH = 32
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic prbs_en_i,
	input wire logic rx_bit_i,
	input wire logic rx_valid_i,
	input wire logic [6:0] prbs_seed_i,
	output logic [COUNT_WIDTH-1:0] correct_cnt_o,
	output logic [COUNT_WIDTH-1:0] total_cnt_o
);
	localparam int LFSR_LEN = 7;

	logic [LFSR_LEN-1:0] lfsr;
	logic en_q;
	logic start;
	logic exp_bit;

	assign start = prbs_en_i && !en_q;

	// New x^7 + x^6 + 1 feedback bit is also the expected data bit
	assign exp_bit = lfsr[6] ^ lfsr[5];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			en_q <= 1'b0;
			lfsr <= LFSR_LEN'(1);
			correct_cnt_o <= '0;
			total_cnt_o <= '0;
		end else begin
			en_q <= prbs_en_i;
			if (start) begin
				// All-zero seed would lock the LFSR
				lfsr <= (prbs_seed_i == '0) ? LFSR_LEN'(1) : prbs_seed_i;
				correct_cnt_o <= '0;
				total_cnt_o <= '0;
			end else if (prbs_en_i && rx_valid_i) begin
				lfsr <= {lfsr[LFSR_LEN-2:0], exp_bit};
				total_cnt_o <= total_cnt_o + 1'b1;
				if (rx_bit_i == exp_bit)
					correct_cnt_o <= correct_cnt_o + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst_i)
		correct_cnt_o <= total_cnt_o);

endmodule

`default_nettype wire

/* jtag.sv */
`default_nettype none

module jtag import dbg_reg_pkg::*; (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	input wire logic rx_bit_i,
	input wire logic rx_valid_i,
	input wire logic [REG_DATA_WIDTH-1:0] stat_i,
	output logic tdo_o,
	output logic [REG_DATA_WIDTH-1:0] ctrl_o
);
	localparam int COUNT_WIDTH = 32;

	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic trst_n_s;
	logic [REG_ADDR_WIDTH-1:0] reg_addr;
	logic [REG_DATA_WIDTH-1:0] wr_data;
	logic [REG_DATA_WIDTH-1:0] rd_data;
	logic wr_en;
	logic prbs_en;
	logic [6:0] prbs_seed;
	logic [COUNT_WIDTH-1:0] correct_cnt;
	logic [COUNT_WIDTH-1:0] total_cnt;

	// No TDO output enable at this level
	jtag_pin_sync i_pin_sync (
		.clk(clk), .rst_i(rst_i),
		.tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i), .trst_n_i(trst_n_i),
		.tck_rise_o(tck_rise), .tck_fall_o(tck_fall),
		.tms_o(tms_s), .tdi_o(tdi_s), .trst_n_o(trst_n_s)
	);

	jtag_tap i_tap (
		.clk(clk), .rst_i(rst_i),
		.tck_rise_i(tck_rise), .tck_fall_i(tck_fall),
		.tms_i(tms_s), .tdi_i(tdi_s), .trst_n_i(trst_n_s),
		.rd_data_i(rd_data), .tdo_o(tdo_o),
		.reg_addr_o(reg_addr), .wr_data_o(wr_data), .wr_en_o(wr_en)
	);

	dbg_reg_file #(.COUNT_WIDTH(COUNT_WIDTH)) i_reg_file (
		.clk(clk), .rst_i(rst_i),
		.wr_en_i(wr_en), .reg_addr_i(reg_addr), .wr_data_i(wr_data),
		.stat_i(stat_i), .correct_cnt_i(correct_cnt), .total_cnt_i(total_cnt),
		.rd_data_o(rd_data), .ctrl_o(ctrl_o),
		.prbs_en_o(prbs_en), .prbs_seed_o(prbs_seed)
	);

	prbs_checker #(.COUNT_WIDTH(COUNT_WIDTH)) i_prbs_checker (
		.clk(clk), .rst_i(rst_i),
		.prbs_en_i(prbs_en), .rx_bit_i(rx_bit_i), .rx_valid_i(rx_valid_i),
		.prbs_seed_i(prbs_seed),
		.correct_cnt_o(correct_cnt), .total_cnt_o(total_cnt)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* jtag_tb.sv */
module jtag_tb import jtag_pkg::*, dbg_reg_pkg::*; ();

	localparam int TCK_HALF = 6;
	localparam int PRBS_BITS = 200;
	localparam int IR_TCK = 10;
	localparam int ACCESS_TCK = 2 * IR_TCK + (REG_ADDR_WIDTH + 5) + (REG_DATA_WIDTH + 5);
	// TCK cycles of all tests with the PRBS feed counted in TCK cycles
	localparam int RUN_TCK = 38 + 2 * (IR_TCK + 38) + 16 * ACCESS_TCK
		+ PRBS_BITS * 4 / (2 * TCK_HALF) + 2 * IR_TCK + 84;
	localparam int TIMEOUT_CYCLES = 2 * RUN_TCK * 2 * TCK_HALF;

	logic clk;
	logic rst_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic rx_bit_i;
	logic rx_valid_i;
	logic [REG_DATA_WIDTH-1:0] stat_i;
	logic tdo_o;
	logic [REG_DATA_WIDTH-1:0] ctrl_o;

	// Register file and checker model
	logic [REG_DATA_WIDTH-1:0] m_ctrl;
	logic [REG_DATA_WIDTH-1:0] m_mode;
	logic [REG_DATA_WIDTH-1:0] m_init;
	logic [6:0] m_lfsr;
	logic [31:0] m_total;
	logic [31:0] m_correct;

	int cycle_cnt = 0;
	int test_errs;
	int tests_ok;
	int tests_bad;

	tb_clock #(.PERIOD(8)) i_clock (.clk_o(clk));

	jtag i_jtag (
		.clk(clk), .rst_i(rst_i),
		.tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i), .trst_n_i(trst_n_i),
		.rx_bit_i(rx_bit_i), .rx_valid_i(rx_valid_i), .stat_i(stat_i),
		.tdo_o(tdo_o), .ctrl_o(ctrl_o)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d clk cycles, the TAP sequence never completed", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			tests_ok++;
			$display("%s: done, no errors", name);
		end else begin
			tests_bad++;
			$display("%s: done, %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// One TCK period; TDO is taken just before the rising edge
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		repeat (TCK_HALF) @(posedge clk);
		#1;
		tdo = tdo_o;
		tck_i = 1'b1;
		repeat (TCK_HALF) @(posedge clk);
		#1;
	endtask

	task automatic tms_step(input logic tms);
		logic unused;
		tck_cycle(tms, 1'b0, unused);
	endtask

	task automatic reset_tap_by_tms();
		repeat (5) tms_step(1'b1);
		tms_step(1'b0);
	endtask

	// Idle to Idle through Shift-IR
	task automatic scan_ir(input logic [IR_WIDTH-1:0] code);
		logic [IR_WIDTH-1:0] cur;
		logic unused;
		cur = code;
		tms_step(1'b1);
		tms_step(1'b1);
		tms_step(1'b0);
		tms_step(1'b0);
		for (int i = 0; i < IR_WIDTH; i++) begin
			tck_cycle(i == IR_WIDTH - 1, cur[0], unused);
			cur = cur >> 1;
		end
		tms_step(1'b1);
		tms_step(1'b0);
	endtask

	// Idle to Idle through Shift-DR with LSB first both ways
	task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
		logic [63:0] cur;
		logic bit_out;
		cur = din;
		dout = '0;
		tms_step(1'b1);
		tms_step(1'b0);
		tms_step(1'b0);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, cur[0], bit_out);
			cur = cur >> 1;
			dout = {bit_out, dout[63:1]};
		end
		tms_step(1'b1);
		tms_step(1'b0);
		dout = dout >> (64 - len);
	endtask

	function automatic logic [REG_DATA_WIDTH-1:0] model_read(input logic [REG_ADDR_WIDTH-1:0] addr);
		case (addr)
			ADDR_CTRL:       return m_ctrl;
			ADDR_PRBS_MODE:  return m_mode;
			ADDR_PRBS_INIT:  return m_init;
			ADDR_STAT_EXT:   return stat_i;
			ADDR_CORRECT_LO: return m_correct[15:0];
			ADDR_CORRECT_HI: return m_correct[31:16];
			ADDR_TOTAL_LO:   return m_total[15:0];
			ADDR_TOTAL_HI:   return m_total[31:16];
			default:         return 16'h0000;
		endcase
	endfunction

	function automatic void model_write(input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] data);
		case (addr)
			ADDR_CTRL:      m_ctrl = data;
			ADDR_PRBS_INIT: m_init = data;
			ADDR_PRBS_MODE: begin
				// Enable edge reloads the seed and clears the counts
				if (data[0] && !m_mode[0]) begin
					m_lfsr = (m_init[6:0] == 7'd0) ? 7'd1 : m_init[6:0];
					m_total = '0;
					m_correct = '0;
				end
				m_mode = data;
			end
			default: ;
		endcase
	endfunction

	// Every access reads the captured word and writes wdata
	task automatic reg_rw(input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] wdata, input string name);
		logic [63:0] dout;
		logic [REG_DATA_WIDTH-1:0] exp_rd;
		scan_ir(INSTR_REG_ADDR);
		scan_dr(REG_ADDR_WIDTH, 64'(addr), dout);
		scan_ir(INSTR_REG_DATA);
		exp_rd = model_read(addr);
		scan_dr(REG_DATA_WIDTH, 64'(wdata), dout);
		check_val(name, 32'(exp_rd), 32'(dout[15:0]));
		model_write(addr, wdata);
	endtask

	task automatic bypass_scan(input logic [IR_WIDTH-1:0] code);
		logic [31:0] pattern;
		logic [63:0] dout;
		pattern = $urandom();
		scan_ir(code);
		// One extra shift flushes the last pattern bit
		scan_dr(33, 64'(pattern), dout);
		check_val("tdo_o first bit", 32'd0, 32'(dout[0]));
		check_val("tdo_o bypass", pattern, dout[32:1]);
	endtask

	// x^7 + x^6 + 1 sequence with random gaps and flipped bits
	task automatic feed_prbs(input int count);
		logic exp_bit;
		logic flip;
		int flips;
		flips = 0;
		for (int n = 0; n < count; n++) begin
			repeat ($urandom_range(3, 0)) begin
				rx_valid_i = 1'b0;
				rx_bit_i = 1'($urandom());
				@(posedge clk);
				#1;
			end
			exp_bit = m_lfsr[6] ^ m_lfsr[5];
			m_lfsr = {m_lfsr[5:0], exp_bit};
			flip = ($urandom_range(7, 0) == 0);
			if (flip)
				flips++;
			rx_bit_i = exp_bit ^ flip;
			rx_valid_i = 1'b1;
			@(posedge clk);
			#1;
		end
		rx_valid_i = 1'b0;
		m_total = m_total + 32'(count);
		m_correct = m_correct + 32'(count - flips);
	endtask

	initial begin
		logic [63:0] dout;
		logic [REG_ADDR_WIDTH-1:0] addr;
		logic [IR_WIDTH-1:0] code;
		void'($urandom(32'hbc73_fb2f));
		rst_i = 1'b1;
		tck_i = 1'b0;
		tms_i = 1'b0;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		rx_bit_i = 1'b0;
		rx_valid_i = 1'b0;
		stat_i = '0;
		m_ctrl = CTRL_RESET;
		m_mode = '0;
		m_init = PRBS_INIT_RESET;
		m_lfsr = 7'd1;
		m_total = '0;
		m_correct = '0;
		test_errs = 0;
		tests_ok = 0;
		tests_bad = 0;
		repeat (4) @(posedge clk);
		#1;
		rst_i = 1'b0;

		check_val("tdo_o", 32'd0, 32'(tdo_o));
		check_val("ctrl_o", 32'(CTRL_RESET), 32'(ctrl_o));
		tms_step(1'b0);
		scan_dr(32, 64'($urandom()), dout);
		check_val("tdo_o idcode", IDCODE_VALUE, dout[31:0]);
		end_test("idcode after reset");

		bypass_scan(INSTR_BYPASS);
		do
			code = 4'($urandom());
		while (code inside {INSTR_IDCODE, INSTR_REG_ADDR, INSTR_REG_DATA, INSTR_BYPASS});
		bypass_scan(code);
		end_test("bypass");

		reg_rw(ADDR_CTRL, 16'($urandom()), "rd_data ctrl before write");
		tms_step(1'b0);
		check_val("ctrl_o", 32'(m_ctrl), 32'(ctrl_o));
		reg_rw(ADDR_CTRL, m_ctrl, "rd_data ctrl");
		reg_rw(ADDR_STAT_EXT, 16'($urandom()), "rd_data stat_ext before write");
		reg_rw(ADDR_STAT_EXT, 16'($urandom()), "rd_data stat_ext after write");
		reg_rw(ADDR_TOTAL_LO, 16'($urandom()), "rd_data total_lo before write");
		reg_rw(ADDR_TOTAL_LO, 16'($urandom()), "rd_data total_lo after write");
		do
			addr = 8'($urandom());
		while (addr inside {ADDR_CTRL, ADDR_PRBS_MODE, ADDR_PRBS_INIT, ADDR_STAT_EXT,
			ADDR_CORRECT_LO, ADDR_CORRECT_HI, ADDR_TOTAL_LO, ADDR_TOTAL_HI});
		reg_rw(addr, 16'($urandom()), "rd_data unmapped before write");
		reg_rw(addr, 16'($urandom()), "rd_data unmapped after write");
		end_test("config access");

		stat_i = 16'($urandom());
		reg_rw(ADDR_STAT_EXT, 16'($urandom()), "rd_data stat_ext");
		end_test("status read");

		reg_rw(ADDR_PRBS_INIT, 16'($urandom()), "rd_data prbs_init");
		reg_rw(ADDR_PRBS_MODE, 16'h0001, "rd_data prbs_mode");
		feed_prbs(PRBS_BITS);
		reg_rw(ADDR_TOTAL_LO, 16'($urandom()), "rd_data total_lo");
		reg_rw(ADDR_TOTAL_HI, 16'($urandom()), "rd_data total_hi");
		reg_rw(ADDR_CORRECT_LO, 16'($urandom()), "rd_data correct_lo");
		reg_rw(ADDR_CORRECT_HI, 16'($urandom()), "rd_data correct_hi");
		end_test("prbs counters");

		scan_ir(INSTR_BYPASS);
		reset_tap_by_tms();
		scan_dr(32, 64'($urandom()), dout);
		check_val("tdo_o idcode after tms reset", IDCODE_VALUE, dout[31:0]);
		scan_ir(INSTR_REG_DATA);
		trst_n_i = 1'b0;
		repeat (2 * TCK_HALF) @(posedge clk);
		#1;
		trst_n_i = 1'b1;
		repeat (TCK_HALF) @(posedge clk);
		#1;
		tms_step(1'b0);
		scan_dr(32, 64'($urandom()), dout);
		check_val("tdo_o idcode after trst", IDCODE_VALUE, dout[31:0]);
		check_val("ctrl_o", 32'(m_ctrl), 32'(ctrl_o));
		reg_rw(ADDR_PRBS_INIT, m_init, "rd_data prbs_init after tap reset");
		end_test("tap reset");

		$display("tests: %0d without errors, %0d with errors", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* tb.f */
jtag_pkg.sv
dbg_reg_pkg.sv
jtag_pin_sync.sv
jtag_tap.sv
dbg_reg_file.sv
prbs_checker.sv
jtag.sv
tb_clock.sv
jtag_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= jtag_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
